/* include/decode_params.svh */
/*
 * Widths shared by the decode stage. RV64 only, 32-bit instructions,
 * no compressed extension, so targets must keep 4-byte alignment.
 */

`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// data and address width
`define XLEN 64

// instruction width, no RVC
`define ILEN 32

// register index width
`define REG_ADDR_W 5

// low target bits that have to be zero for a legal jump
`define INST_ALIGN_BITS 2

`endif

/* src/decode_pkg.sv */
/*
 * Types of the decode stage. Widths come from decode_params.svh.
 * Only the RV64IM subset is listed, FP opcodes have no entry here.
 */

`include "decode_params.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [6:0] {
        OP_LUI     = 7'b0110111,
        OP_AUIPC   = 7'b0010111,
        OP_JAL     = 7'b1101111,
        OP_JALR    = 7'b1100111,
        OP_BRANCH  = 7'b1100011,
        OP_LOAD    = 7'b0000011,
        OP_STORE   = 7'b0100011,
        OP_ALU_I   = 7'b0010011,
        OP_ALU     = 7'b0110011,
        OP_ALU_I_W = 7'b0011011,
        OP_ALU_W   = 7'b0111011
    } opcode_e;

    typedef enum logic [5:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        JAL, JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LD, LBU, LHU, LWU,
        SB, SH, SW, SD,
        MUL, MULH, MULHSU, MULHU, DIV, DIVU, REM, REMU,
        MULW, DIVW, DIVUW, REMW, REMUW
    } op_type_e;

    typedef enum logic [2:0] {
        UNIT_ALU,
        UNIT_BRANCH,
        UNIT_MEM,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    // mcause encodings, NONE sits outside the used range
    typedef enum logic [3:0] {
        INSTR_ADDR_MISALIGNED = 4'd0,
        ILLEGAL_INSTR         = 4'd2,
        NONE                  = 4'd15
    } xcpt_cause_e;

    typedef struct packed {
        logic        valid;
        xcpt_cause_e cause;
        xlen_t       origin; // faulting address, 0 when unused
    } xcpt_t;

    typedef struct packed {
        logic             valid;
        xlen_t            pc;
        logic [`ILEN-1:0] inst;
        xcpt_t            xcpt;
    } fetch_t;

    typedef struct packed {
        logic       valid;
        xlen_t      pc;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        op_type_e   op_type;
        unit_e      unit;
        logic       regfile_we;
        logic       use_imm;
        logic       use_pc;
        logic       op_32;
        logic       signed_op;
        logic [2:0] mem_size; // raw funct3
        xlen_t      imm;
        logic       illegal;
        xcpt_t      xcpt;
    } decoded_t;

    typedef struct packed {
        logic  valid;
        xlen_t addr;
    } jump_t;

endpackage

/* src/imm_gen.sv */
/*
 * Immediate builder. The format is picked from the opcode only, so
 * R-type and unknown opcodes give zero.
 */

`timescale 1ns/10ps

`include "decode_params.svh"

module imm_gen (
    input  logic [`ILEN-1:0] inst_i,
    output decode_pkg::xlen_t imm_o
);

    import decode_pkg::*;

    always_comb begin
        case (opcode_e'(inst_i[6:0]))
            OP_LOAD, OP_ALU_I, OP_ALU_I_W, OP_JALR: begin
                imm_o = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
            end
            OP_STORE: begin
                imm_o = {{(`XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            end
            OP_BRANCH: begin
                imm_o = {{(`XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                // upper 20 bits, already shifted by 12
                imm_o = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
            end
            OP_JAL: begin
                imm_o = {{(`XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            end
            default: begin
                imm_o = '0;
            end
        endcase
    end

endmodule

/* src/instr_decoder.sv */
/*
 * RV64IM field decoder, combinational. Opcodes outside the kept set
 * (FP, system, atomics, fence) decode as illegal. An incoming exception
 * skips decoding and is copied into the entry unchanged.
 */

`timescale 1ns/10ps

module instr_decoder (
    input  decode_pkg::fetch_t   fetch_i,
    input  decode_pkg::xlen_t    imm_i,
    output decode_pkg::decoded_t entry_o
);

    import decode_pkg::*;

    localparam logic [2:0] F3_ADD_SUB = 3'b000, F3_SLL = 3'b001, F3_SLT = 3'b010,
                           F3_SLTU = 3'b011, F3_XOR = 3'b100, F3_SRL_SRA = 3'b101,
                           F3_OR = 3'b110, F3_AND = 3'b111;
    localparam logic [2:0] F3_MUL = 3'b000, F3_MULH = 3'b001, F3_MULHSU = 3'b010,
                           F3_MULHU = 3'b011, F3_DIV = 3'b100, F3_DIVU = 3'b101,
                           F3_REM = 3'b110, F3_REMU = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000, F3_BNE = 3'b001, F3_BLT = 3'b100,
                           F3_BGE = 3'b101, F3_BLTU = 3'b110, F3_BGEU = 3'b111;
    localparam logic [2:0] F3_LB = 3'b000, F3_LH = 3'b001, F3_LW = 3'b010,
                           F3_LD = 3'b011, F3_LBU = 3'b100, F3_LHU = 3'b101,
                           F3_LWU = 3'b110;
    localparam logic [2:0] F3_SB = 3'b000, F3_SH = 3'b001, F3_SW = 3'b010,
                           F3_SD = 3'b011;
    localparam logic [6:0] F7_NORMAL  = 7'b0000000;
    localparam logic [6:0] F7_SUB_SRA = 7'b0100000;
    localparam logic [6:0] F7_MUL_DIV = 7'b0000001;

    opcode_e    opcode;
    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       illegal;
    decoded_t   dec;

    assign opcode = opcode_e'(fetch_i.inst[6:0]);
    assign funct7 = fetch_i.inst[31:25];
    assign funct3 = fetch_i.inst[14:12];

    always_comb begin
        illegal      = 1'b0;
        dec          = '0;
        dec.valid    = fetch_i.valid;
        dec.pc       = fetch_i.pc;
        dec.rs1      = fetch_i.inst[19:15];
        dec.rs2      = fetch_i.inst[24:20];
        dec.rd       = fetch_i.inst[11:7];
        dec.op_type  = ADD;
        dec.unit     = UNIT_ALU;
        dec.mem_size = funct3;
        dec.imm      = imm_i;
        dec.xcpt     = fetch_i.xcpt;

        if (fetch_i.valid && !fetch_i.xcpt.valid) begin
            case (opcode)
                OP_LUI: begin
                    dec.regfile_we = 1'b1;
                    dec.use_imm    = 1'b1;
                    dec.rs1        = '0; // x0 | imm
                    dec.op_type    = OR;
                end
                OP_AUIPC: begin
                    dec.regfile_we = 1'b1;
                    dec.use_imm    = 1'b1;
                    dec.use_pc     = 1'b1;
                end
                OP_JAL: begin
                    dec.regfile_we = 1'b1; // link pc+4
                    dec.use_imm    = 1'b1;
                    dec.use_pc     = 1'b1;
                    dec.op_type    = JAL;
                    dec.unit       = UNIT_BRANCH;
                end
                OP_JALR: begin
                    dec.regfile_we = 1'b1;
                    dec.use_imm    = 1'b1;
                    dec.use_pc     = 1'b1;
                    dec.op_type    = JALR;
                    dec.unit       = UNIT_BRANCH;
                    illegal        = (funct3 != 3'b000);
                end
                OP_BRANCH: begin
                    dec.use_imm = 1'b1;
                    dec.use_pc  = 1'b1;
                    dec.unit    = UNIT_BRANCH;
                    case (funct3)
                        F3_BEQ:  dec.op_type = BEQ;
                        F3_BNE:  dec.op_type = BNE;
                        F3_BLT:  dec.op_type = BLT;
                        F3_BGE:  dec.op_type = BGE;
                        F3_BLTU: dec.op_type = BLTU;
                        F3_BGEU: dec.op_type = BGEU;
                        default: illegal = 1'b1;
                    endcase
                end
                OP_LOAD: begin
                    dec.regfile_we = 1'b1;
                    dec.use_imm    = 1'b1;
                    dec.unit       = UNIT_MEM;
                    case (funct3)
                        F3_LB:   dec.op_type = LB;
                        F3_LH:   dec.op_type = LH;
                        F3_LW:   dec.op_type = LW;
                        F3_LD:   dec.op_type = LD;
                        F3_LBU:  dec.op_type = LBU;
                        F3_LHU:  dec.op_type = LHU;
                        F3_LWU:  dec.op_type = LWU;
                        default: illegal = 1'b1;
                    endcase
                end
                OP_STORE: begin
                    dec.use_imm = 1'b1;
                    dec.unit    = UNIT_MEM;
                    case (funct3)
                        F3_SB:   dec.op_type = SB;
                        F3_SH:   dec.op_type = SH;
                        F3_SW:   dec.op_type = SW;
                        F3_SD:   dec.op_type = SD;
                        default: illegal = 1'b1;
                    endcase
                end
                OP_ALU_I: begin
                    dec.regfile_we = 1'b1;
                    dec.use_imm    = 1'b1;
                    case (funct3)
                        F3_ADD_SUB: dec.op_type = ADD;
                        F3_SLT:     dec.op_type = SLT;
                        F3_SLTU:    dec.op_type = SLTU;
                        F3_XOR:     dec.op_type = XOR;
                        F3_OR:      dec.op_type = OR;
                        F3_AND:     dec.op_type = AND;
                        F3_SLL: begin
                            dec.op_type = SLL;
                            // 6-bit shamt, only funct7[6:1] is checked
                            illegal = (funct7[6:1] != F7_NORMAL[6:1]);
                        end
                        default: begin
                            if (funct7[6:1] == F7_SUB_SRA[6:1]) begin
                                dec.op_type = SRA;
                            end else if (funct7[6:1] == F7_NORMAL[6:1]) begin
                                dec.op_type = SRL;
                            end else begin
                                illegal = 1'b1;
                            end
                        end
                    endcase
                end
                OP_ALU: begin
                    dec.regfile_we = 1'b1;
                    case ({funct7, funct3})
                        {F7_NORMAL, F3_ADD_SUB}:  dec.op_type = ADD;
                        {F7_SUB_SRA, F3_ADD_SUB}: dec.op_type = SUB;
                        {F7_NORMAL, F3_SLL}:      dec.op_type = SLL;
                        {F7_NORMAL, F3_SLT}:      dec.op_type = SLT;
                        {F7_NORMAL, F3_SLTU}:     dec.op_type = SLTU;
                        {F7_NORMAL, F3_XOR}:      dec.op_type = XOR;
                        {F7_NORMAL, F3_SRL_SRA}:  dec.op_type = SRL;
                        {F7_SUB_SRA, F3_SRL_SRA}: dec.op_type = SRA;
                        {F7_NORMAL, F3_OR}:       dec.op_type = OR;
                        {F7_NORMAL, F3_AND}:      dec.op_type = AND;
                        {F7_MUL_DIV, F3_MUL}:     dec.op_type = MUL;
                        {F7_MUL_DIV, F3_MULH}:    dec.op_type = MULH;
                        {F7_MUL_DIV, F3_MULHSU}:  dec.op_type = MULHSU;
                        {F7_MUL_DIV, F3_MULHU}:   dec.op_type = MULHU;
                        {F7_MUL_DIV, F3_DIV}:     dec.op_type = DIV;
                        {F7_MUL_DIV, F3_DIVU}:    dec.op_type = DIVU;
                        {F7_MUL_DIV, F3_REM}:     dec.op_type = REM;
                        {F7_MUL_DIV, F3_REMU}:    dec.op_type = REMU;
                        default:                  illegal = 1'b1;
                    endcase
                end
                OP_ALU_I_W: begin
                    dec.regfile_we = 1'b1;
                    dec.use_imm    = 1'b1;
                    dec.op_32      = 1'b1;
                    case (funct3)
                        F3_ADD_SUB: dec.op_type = ADDW;
                        F3_SLL: begin
                            dec.op_type = SLLW;
                            illegal     = (funct7 != F7_NORMAL);
                        end
                        F3_SRL_SRA: begin
                            dec.op_type = (funct7 == F7_SUB_SRA) ? SRAW : SRLW;
                            illegal     = (funct7 != F7_SUB_SRA) && (funct7 != F7_NORMAL);
                        end
                        default: illegal = 1'b1;
                    endcase
                end
                OP_ALU_W: begin
                    dec.regfile_we = 1'b1;
                    dec.op_32      = 1'b1;
                    case ({funct7, funct3})
                        {F7_NORMAL, F3_ADD_SUB}:  dec.op_type = ADDW;
                        {F7_SUB_SRA, F3_ADD_SUB}: dec.op_type = SUBW;
                        {F7_NORMAL, F3_SLL}:      dec.op_type = SLLW;
                        {F7_NORMAL, F3_SRL_SRA}:  dec.op_type = SRLW;
                        {F7_SUB_SRA, F3_SRL_SRA}: dec.op_type = SRAW;
                        {F7_MUL_DIV, F3_MUL}:     dec.op_type = MULW;
                        {F7_MUL_DIV, F3_DIV}:     dec.op_type = DIVW;
                        {F7_MUL_DIV, F3_DIVU}:    dec.op_type = DIVUW;
                        {F7_MUL_DIV, F3_REM}:     dec.op_type = REMW;
                        {F7_MUL_DIV, F3_REMU}:    dec.op_type = REMUW;
                        default:                  illegal = 1'b1;
                    endcase
                end
                default: illegal = 1'b1; // fp, system, amo, fence
            endcase

            // M extension, funct3[2] splits mul from div/rem
            if ((opcode == OP_ALU || opcode == OP_ALU_W) && funct7 == F7_MUL_DIV) begin
                dec.unit      = funct3[2] ? UNIT_DIV : UNIT_MUL;
                dec.signed_op = funct3[2] & ~funct3[0]; // div, rem
            end
        end
    end

    // illegal entries fall back to a harmless add with nothing enabled
    always_comb begin
        entry_o         = dec;
        entry_o.illegal = illegal;
        if (illegal) begin
            entry_o.op_type    = ADD;
            entry_o.unit       = UNIT_ALU;
            entry_o.regfile_we = 1'b0;
            entry_o.use_imm    = 1'b0;
            entry_o.use_pc     = 1'b0;
            entry_o.op_32      = 1'b0;
            entry_o.signed_op  = 1'b0;
        end
    end

endmodule

/* src/stage_reg.sv */
/*
 * Pipeline register for any packed struct with a valid field.
 * Only valid is cleared by reset or flush, the payload just follows d_i.
 */

`timescale 1ns/10ps

module stage_reg #(
    parameter type payload_t = decode_pkg::fetch_t
) (
    input  logic     clk_i,
    input  logic     rst_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk_i) begin
        q_o <= d_i;
        if (rst_i || flush_i) begin
            q_o.valid <= 1'b0; // drop whatever is in flight
        end
    end

endmodule

/* src/jump_xcpt_unit.sv */
/*
 * JAL redirect and final exception record, combinational.
 * Priority: incoming exception, then JAL misalignment, then illegal.
 * Assumes pc is already aligned, so only the offset is checked.
 */

`timescale 1ns/10ps

`include "decode_params.svh"

module jump_xcpt_unit (
    input  decode_pkg::decoded_t entry_i,
    output decode_pkg::decoded_t decoded_o,
    output decode_pkg::jump_t    jump_o
);

    import decode_pkg::*;

    xlen_t target;
    logic  is_jal;
    logic  misaligned;

    assign target     = entry_i.pc + entry_i.imm;
    assign misaligned = |entry_i.imm[`INST_ALIGN_BITS-1:0];
    assign is_jal     = entry_i.valid && !entry_i.xcpt.valid && (entry_i.op_type == JAL);

    always_comb begin
        decoded_o = entry_i;
        if (entry_i.xcpt.valid) begin
            decoded_o.xcpt = entry_i.xcpt; // older fault wins
        end else if (is_jal && misaligned) begin
            decoded_o.xcpt.valid  = 1'b1;
            decoded_o.xcpt.cause  = INSTR_ADDR_MISALIGNED;
            decoded_o.xcpt.origin = target;
        end else if (entry_i.illegal) begin
            decoded_o.xcpt.valid  = 1'b1;
            decoded_o.xcpt.cause  = ILLEGAL_INSTR;
            decoded_o.xcpt.origin = '0;
        end else begin
            decoded_o.xcpt.valid  = 1'b0;
            decoded_o.xcpt.cause  = NONE;
            decoded_o.xcpt.origin = '0;
        end
    end

    assign jump_o.valid = is_jal && !misaligned;
    assign jump_o.addr  = target;

endmodule

/* src/decode_stage.sv */
/*
 * Decode stage top: fetch register, decoder, decode register, jump unit.
 * Fixed 2-cycle latency, no back-pressure, flush kills both stages.
 */

`timescale 1ns/10ps

module decode_stage (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 flush_i,
    input  decode_pkg::fetch_t   fetch_i,
    output decode_pkg::decoded_t decoded_o,
    output decode_pkg::jump_t    jump_o
);

    import decode_pkg::*;

    fetch_t   fetch_q;
    xlen_t    imm;
    decoded_t dec;
    decoded_t dec_q;

    stage_reg #(.payload_t(fetch_t)) u_fetch_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .d_i     (fetch_i),
        .q_o     (fetch_q)
    );

    imm_gen u_imm_gen (
        .inst_i (fetch_q.inst),
        .imm_o  (imm)
    );

    instr_decoder u_decoder (
        .fetch_i (fetch_q),
        .imm_i   (imm),
        .entry_o (dec)
    );

    stage_reg #(.payload_t(decoded_t)) u_decode_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .flush_i (flush_i),
        .d_i     (dec),
        .q_o     (dec_q)
    );

    jump_xcpt_unit u_jump_xcpt (
        .entry_i   (dec_q),
        .decoded_o (decoded_o),
        .jump_o    (jump_o)
    );

endmodule

/* verif/decode_checker.sv */
/*
 * Scoreboard for the decode stage. Each expected entry is due two clock
 * edges after its strobe is seen. A valid output with nothing due is an error.
 */

`timescale 1ns/10ps

module decode_checker (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 exp_strobe_i,
    input  int                   exp_row_i,
    input  decode_pkg::decoded_t exp_entry_i,
    input  decode_pkg::jump_t    exp_jump_i,
    input  int                   total_i,
    input  decode_pkg::decoded_t decoded_i,
    input  decode_pkg::jump_t    jump_i,
    output int                   checked_o,
    output int                   errors_o
);

    import decode_pkg::*;

    typedef struct packed {
        int       due;
        int       row;
        decoded_t entry;
        jump_t    jump;
    } pending_t;

    pending_t pending[$];
    int       cycle;

    // fields that are compared, only valid for a dropped entry
    function automatic decoded_t visible(decoded_t d, logic full);
        decoded_t v;
        v       = '0;
        v.valid = d.valid;
        if (full) begin
            v.pc         = d.pc;
            v.rs1        = d.rs1;
            v.rs2        = d.rs2;
            v.rd         = d.rd;
            v.op_type    = d.op_type;
            v.unit       = d.unit;
            v.regfile_we = d.regfile_we;
            v.use_imm    = d.use_imm;
            v.use_pc     = d.use_pc;
            v.op_32      = d.op_32;
            v.signed_op  = d.signed_op;
            v.mem_size   = d.mem_size;
            v.imm        = d.imm;
            v.illegal    = d.illegal;
            v.xcpt       = d.xcpt;
        end
        return v;
    endfunction

    function automatic jump_t visible_jump(jump_t j, logic addr_on);
        jump_t v;
        v.valid = j.valid;
        v.addr  = addr_on ? j.addr : '0;
        return v;
    endfunction

    always @(posedge clk_i) begin
        pending_t p;
        int       bad;
        cycle++;
        bad = 0;
        if (rst_i) begin
            pending.delete();
        end else begin
            if (pending.size() > 0 && pending[0].due == cycle) begin
                p = pending.pop_front();
                if (visible(decoded_i, p.entry.valid) !== visible(p.entry, p.entry.valid)) begin
                    $display("ERR %0t row %0d entry got v%b %s %s %s, exp v%b %s %s %s",
                             $time, p.row, decoded_i.valid, decoded_i.op_type.name(),
                             decoded_i.unit.name(), decoded_i.xcpt.cause.name(),
                             p.entry.valid, p.entry.op_type.name(), p.entry.unit.name(),
                             p.entry.xcpt.cause.name());
                    bad++;
                end
                if (visible_jump(jump_i, p.jump.valid) !== visible_jump(p.jump, p.jump.valid)) begin
                    $display("ERR %0t row %0d jump got v%b %h, exp v%b %h",
                             $time, p.row, jump_i.valid, jump_i.addr, p.jump.valid, p.jump.addr);
                    bad++;
                end
                if (bad == 0) begin
                    $display("row %0d ok", p.row);
                end else begin
                    $display("row %0d has %0d mismatches", p.row, bad);
                end
                errors_o  = errors_o + bad;
                checked_o = checked_o + 1;
                if (checked_o == total_i) begin
                    $display("checked %0d rows, %0d errors", checked_o, errors_o);
                end
            end else if (decoded_i.valid || jump_i.valid) begin
                $display("ERR %0t valid output with no entry due", $time);
                errors_o = errors_o + 1;
            end
            if (exp_strobe_i) begin
                p.due   = cycle + 2; // fetch reg, then decode reg
                p.row   = exp_row_i;
                p.entry = exp_entry_i;
                p.jump  = exp_jump_i;
                pending.push_back(p);
            end
        end
    end

endmodule

/* verif/tb_decode_stage.sv */
/*
 * Testbench for decode_stage. Table rows go in one per clock, back to
 * back, PCs are random but word aligned. Expected values follow the
 * decode, exception priority and flush rules of the stage.
 */

`timescale 1ns/10ps

module tb_decode_stage;

    import decode_pkg::*;

    localparam int RESET_CYCLES = 8;

    typedef struct packed {
        logic [31:0] inst;
        xlen_t       pc;
        logic        xin;   // fault raised before decode
        logic        flush;
        logic        keep;  // 0 when a flush drops the entry
        op_type_e    op;
        unit_e       unit;
        logic [4:0]  flags; // we, imm, pc, op32, signed
        xcpt_cause_e cause;
        logic        jmp;
        xlen_t       off;   // immediate, also the jal offset
    } row_t;

    logic     clk;
    logic     rst;
    logic     flush;
    fetch_t   fetch;
    decoded_t decoded;
    jump_t    jump;
    logic     exp_strobe;
    int       exp_row;
    decoded_t exp_entry;
    jump_t    exp_jump;
    int       total;
    int       checked;
    int       errors;
    int       cycle_cnt;
    row_t     rows[$];

    decode_stage u_decode_stage (
        .clk_i     (clk),
        .rst_i     (rst),
        .flush_i   (flush),
        .fetch_i   (fetch),
        .decoded_o (decoded),
        .jump_o    (jump)
    );

    decode_checker u_checker (
        .clk_i        (clk),
        .rst_i        (rst),
        .exp_strobe_i (exp_strobe),
        .exp_row_i    (exp_row),
        .exp_entry_i  (exp_entry),
        .exp_jump_i   (exp_jump),
        .total_i      (total),
        .decoded_i    (decoded),
        .jump_i       (jump),
        .checked_o    (checked),
        .errors_o     (errors)
    );

    always #10 clk = ~clk;

    // encoders, rs1 = x1, rs2 = x2, rd = x3
    function automatic logic [31:0] enc_r(int f7, int f3, int op);
        return {f7[6:0], 5'd2, 5'd1, f3[2:0], 5'd3, op[6:0]};
    endfunction

    function automatic logic [31:0] enc_i(int imm, int f3, int op);
        return {imm[11:0], 5'd1, f3[2:0], 5'd3, op[6:0]};
    endfunction

    function automatic logic [31:0] enc_u(int imm, int op);
        return {imm[19:0], 5'd3, op[6:0]};
    endfunction

    function automatic logic [31:0] enc_j(int off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'h6f};
    endfunction

    function automatic xcpt_t incoming_xcpt(row_t r);
        xcpt_t x;
        x = '{valid: 1'b0, cause: NONE, origin: '0};
        if (r.xin) begin
            x = '{valid: 1'b1, cause: INSTR_ADDR_MISALIGNED, origin: r.pc + 64'd2};
        end
        return x;
    endfunction

    // older fault first, then jal target, then illegal
    function automatic xcpt_t expected_xcpt(row_t r);
        xcpt_t x;
        x = '{valid: 1'b0, cause: NONE, origin: '0};
        if (r.xin) begin
            x = incoming_xcpt(r);
        end else if (r.cause == INSTR_ADDR_MISALIGNED) begin
            x = '{valid: 1'b1, cause: INSTR_ADDR_MISALIGNED, origin: r.pc + r.off};
        end else if (r.cause == ILLEGAL_INSTR) begin
            x = '{valid: 1'b1, cause: ILLEGAL_INSTR, origin: '0};
        end
        return x;
    endfunction

    function automatic decoded_t expected_entry(row_t r);
        decoded_t e;
        e          = '0;
        e.valid    = r.keep;
        e.pc       = r.pc;
        e.rs1      = (r.inst[6:0] == OP_LUI) ? 5'd0 : r.inst[19:15]; // lui is x0 | imm
        e.rs2      = r.inst[24:20];
        e.rd       = r.inst[11:7];
        e.op_type  = r.op;
        e.unit     = r.unit;
        {e.regfile_we, e.use_imm, e.use_pc, e.op_32, e.signed_op} = r.flags;
        e.mem_size = r.inst[14:12];
        e.imm      = r.off;
        e.illegal  = (r.cause == ILLEGAL_INSTR);
        e.xcpt     = expected_xcpt(r);
        return e;
    endfunction

    function automatic jump_t expected_jump(row_t r);
        jump_t j;
        j.valid = r.jmp;
        j.addr  = r.pc + r.off;
        return j;
    endfunction

    task automatic add_row(input logic [31:0] inst, input logic [2:0] ctl, input op_type_e op,
                           input unit_e unit, input logic [4:0] flags,
                           input xcpt_cause_e cause, input logic jmp, input int off);
        row_t r;
        r.inst                   = inst;
        {r.xin, r.flush, r.keep} = ctl;
        r.op                     = op;
        r.unit                   = unit;
        r.flags                  = flags;
        r.cause                  = cause;
        r.jmp                    = jmp;
        r.off                    = 64'(off);
        r.pc                     = {$urandom(), $urandom()} & ~64'h3;
        rows.push_back(r);
    endtask

    // ctl is {incoming fault, flush, kept}
    task automatic build_table();
        add_row(enc_r('h00, 0, 'h33), 3'b001, ADD, UNIT_ALU, 5'b10000, NONE, 1'b0, 0);
        add_row(enc_r('h20, 0, 'h33), 3'b001, SUB, UNIT_ALU, 5'b10000, NONE, 1'b0, 0);
        add_row(enc_i('hfff, 0, 'h13), 3'b001, ADD, UNIT_ALU, 5'b11000, NONE, 1'b0, -1);
        add_row(enc_i('h43f, 5, 'h13), 3'b001, SRA, UNIT_ALU, 5'b11000, NONE, 1'b0, 'h43f);
        add_row(enc_i('h010, 0, 'h1b), 3'b001, ADDW, UNIT_ALU, 5'b11010, NONE, 1'b0, 'h10);
        add_row(enc_r('h20, 0, 'h3b), 3'b001, SUBW, UNIT_ALU, 5'b10010, NONE, 1'b0, 0);
        add_row(enc_u('h12345, 'h37), 3'b001, OR, UNIT_ALU, 5'b11000, NONE, 1'b0, 'h12345000);
        add_row(enc_u('h00001, 'h17), 3'b001, ADD, UNIT_ALU, 5'b11100, NONE, 1'b0, 'h1000);
        add_row(enc_r('h00, 0, 'h63), 3'b001, BEQ, UNIT_BRANCH, 5'b01100, NONE, 1'b0, 'h802);
        add_row(enc_r('h00, 7, 'h63), 3'b001, BGEU, UNIT_BRANCH, 5'b01100, NONE, 1'b0, 'h802);
        add_row(enc_i('h008, 3, 'h03), 3'b001, LD, UNIT_MEM, 5'b11000, NONE, 1'b0, 8);
        add_row(enc_i('h001, 4, 'h03), 3'b001, LBU, UNIT_MEM, 5'b11000, NONE, 1'b0, 1);
        add_row(enc_r('h00, 2, 'h23), 3'b001, SW, UNIT_MEM, 5'b01000, NONE, 1'b0, 3);
        add_row(enc_r('h01, 0, 'h33), 3'b001, MUL, UNIT_MUL, 5'b10000, NONE, 1'b0, 0);
        add_row(enc_r('h01, 4, 'h33), 3'b001, DIV, UNIT_DIV, 5'b10001, NONE, 1'b0, 0);
        add_row(enc_r('h01, 7, 'h33), 3'b001, REMU, UNIT_DIV, 5'b10000, NONE, 1'b0, 0);
        add_row(enc_r('h01, 4, 'h3b), 3'b001, DIVW, UNIT_DIV, 5'b10011, NONE, 1'b0, 0);
        add_row(enc_r('h01, 6, 'h3b), 3'b001, REMW, UNIT_DIV, 5'b10011, NONE, 1'b0, 0);
        add_row(enc_j(2048), 3'b001, JAL, UNIT_BRANCH, 5'b11100, NONE, 1'b1, 2048);
        add_row(enc_j(-16), 3'b001, JAL, UNIT_BRANCH, 5'b11100, NONE, 1'b1, -16);
        add_row(enc_j(6), 3'b001, JAL, UNIT_BRANCH, 5'b11100, INSTR_ADDR_MISALIGNED, 1'b0, 6);
        // undefined encodings
        add_row(enc_r('h20, 1, 'h33), 3'b001, ADD, UNIT_ALU, 5'b00000, ILLEGAL_INSTR, 1'b0, 0);
        add_row(enc_i('h401, 1, 'h13), 3'b001, ADD, UNIT_ALU, 5'b00000, ILLEGAL_INSTR, 1'b0, 'h401);
        add_row(enc_i('h021, 5, 'h1b), 3'b001, ADD, UNIT_ALU, 5'b00000, ILLEGAL_INSTR, 1'b0, 'h21);
        add_row(enc_i('h000, 2, 'h07), 3'b001, ADD, UNIT_ALU, 5'b00000, ILLEGAL_INSTR, 1'b0, 0);
        add_row(enc_r('h00, 0, 'h53), 3'b001, ADD, UNIT_ALU, 5'b00000, ILLEGAL_INSTR, 1'b0, 0);
        add_row(enc_r('h00, 2, 'h63), 3'b001, ADD, UNIT_ALU, 5'b00000, ILLEGAL_INSTR, 1'b0, 'h802);
        // fault from fetch wins over illegal and jal
        add_row(enc_r('h00, 0, 'h53), 3'b101, ADD, UNIT_ALU, 5'b00000, NONE, 1'b0, 0);
        add_row(enc_j(64), 3'b101, ADD, UNIT_ALU, 5'b00000, NONE, 1'b0, 64);
        // flush drops the two entries in flight
        add_row(enc_j(128), 3'b000, JAL, UNIT_BRANCH, 5'b11100, NONE, 1'b0, 128);
        add_row(enc_r('h20, 0, 'h33), 3'b010, SUB, UNIT_ALU, 5'b10000, NONE, 1'b0, 0);
        add_row(enc_r('h00, 7, 'h33), 3'b001, AND, UNIT_ALU, 5'b10000, NONE, 1'b0, 0);
        add_row(enc_i('h7ff, 6, 'h13), 3'b001, OR, UNIT_ALU, 5'b11000, NONE, 1'b0, 'h7ff);
    endtask

    initial begin
        fetch_t f;
        void'($urandom(68533));
        clk        = 1'b0;
        rst        = 1'b1;
        flush      = 1'b0;
        fetch      = '0;
        exp_strobe = 1'b0;
        exp_row    = 0;
        exp_entry  = '0;
        exp_jump   = '0;
        build_table();
        total = rows.size();
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            f.valid    = 1'b1;
            f.pc       = rows[i].pc;
            f.inst     = rows[i].inst;
            f.xcpt     = incoming_xcpt(rows[i]);
            fetch      <= f;
            flush      <= rows[i].flush;
            exp_strobe <= 1'b1;
            exp_row    <= i;
            exp_entry  <= expected_entry(rows[i]);
            exp_jump   <= expected_jump(rows[i]);
        end
        @(posedge clk);
        fetch.valid <= 1'b0;
        flush       <= 1'b0;
        exp_strobe  <= 1'b0;
        wait (checked == total);
        repeat (2) @(posedge clk); // a few idle cycles for stray outputs
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // run limit from table length
    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < RESET_CYCLES + total + 50) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout after %0d cycles, not every row reached the output", cycle_cnt);
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* all.f */
+incdir+include
src/decode_pkg.sv
src/imm_gen.sv
src/instr_decoder.sv
src/stage_reg.sv
src/jump_xcpt_unit.sv
src/decode_stage.sv
verif/decode_checker.sv
verif/tb_decode_stage.sv

/* Makefile */
# Verilator build and run of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, search $(LOG) for the result"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
